/* all.f */
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_exec.sv
rtl/rv_reg_file.sv
rtl/rv_lsu.sv
rtl/rv_pc_ctrl.sv
rtl/rv_core_top.sv
verif/tb_wb_mem.sv
verif/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rv_core -f all.f \
  --Mdir obj_dir -o tb_rv_core
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/tb_rv_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

/* verif/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  localparam logic [31:0] SEED     = 32'h20cc;
  localparam int          TIMEOUT  = 2000;
  localparam int          MAX_WAIT = 3;
  localparam int          HALT_WAIT = 20; // idle cycles watched after ebreak
  localparam rv_pkg::word_t EBREAK = 32'h0010_0073;

  logic              clk;
  logic              rst;
  rv_pkg::word_t     inst;
  rv_pkg::word_t     pc;
  rv_pkg::dbus_req_t dbus_req;
  rv_pkg::dbus_rsp_t dbus_rsp;
  logic              halted;

  rv_pkg::word_t prog [64];
  rv_pkg::word_t rf [32];   // shadow registers
  rv_pkg::word_t pc_off;
  rv_pkg::word_t exp_pc;
  rv_pkg::word_t r1v;
  rv_pkg::word_t r2v;
  rv_pkg::word_t immi;
  rv_pkg::word_t imms;
  rv_pkg::word_t addr;
  rv_pkg::word_t cap_word;
  rv_pkg::word_t sh;
  rv_pkg::word_t ldv;
  rv_pkg::word_t exp_sel;
  logic          halt_exp;
  logic          ack_q;
  logic          after_rst;
  logic          retired;
  int            cycles;
  int            halt_cycles;
  int            errors;
  int            test_errs;
  int            test_idx;
  int            idx;
  int            test_end [4] = '{8, 14, 28, 36};
  string         test_name [6] = '{"reset", "alu", "store", "load", "jump", "ebreak"};

  rv_core_top i_dut (
    .clk      (clk),
    .rst      (rst),
    .inst     (inst),
    .pc       (pc),
    .dbus_req (dbus_req),
    .dbus_rsp (dbus_rsp),
    .halted   (halted)
  );

  tb_wb_mem #(.MAX_WAIT(MAX_WAIT)) i_mem (
    .clk (clk),
    .rst (rst),
    .req (dbus_req),
    .rsp (dbus_rsp)
  );

  always #4 clk = ~clk;

  // instruction fetch is a plain lookup by pc
  assign pc_off = pc - rv_pkg::RESET_PC;
  assign inst   = (pc_off < 256) ? prog[pc_off[7:2]] : EBREAK;

  function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OP_STORE};
  endfunction

  function automatic rv_pkg::word_t enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OP_JAL};
  endfunction

  task automatic value_err(input string name, input rv_pkg::word_t exp, input rv_pkg::word_t act);
    $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
    errors++;
  endtask

  task automatic report_fail(input string what);
    $display("failure at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic write_reg(input logic [4:0] rd, input rv_pkg::word_t v);
    if (rd != 0) rf[rd] = v;
  endtask

  task automatic finish_test();
    $display("test %s done, errors %0d", test_name[test_idx], errors - test_errs);
    test_errs = errors;
    test_idx++;
  endtask

  // bus protocol rules
  a_stb_cyc: assert property (@(posedge clk) disable iff (rst) dbus_req.stb |-> dbus_req.cyc)
    else report_fail("stb high without cyc");
  a_hold: assert property (@(posedge clk) disable iff (rst)
    (dbus_req.stb && !dbus_rsp.ack) |=>
      $stable({dbus_req.we, dbus_req.adr, dbus_req.sel, dbus_req.dat_w}))
    else report_fail("request changed before ack");

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    void'($urandom(SEED));
    cycles = 0;
    errors = 0;
    test_errs = 0;
    test_idx = 0;
    halt_cycles = 0;
    for (int i = 0; i < 64; i++) prog[i] = EBREAK;
    prog[0]  = {20'h80001, 5'd1, rv_pkg::OP_LUI};      // x1 = data base
    prog[1]  = enc_i(12'hffb, 5'd0, 3'd0, 5'd2, rv_pkg::OP_IMM);
    prog[2]  = enc_i(12'h123, 5'd2, 3'd0, 5'd3, rv_pkg::OP_IMM);
    prog[3]  = {20'habcde, 5'd4, rv_pkg::OP_LUI};
    prog[4]  = {20'h00012, 5'd5, rv_pkg::OP_AUIPC};
    prog[5]  = enc_s(12'd0, 5'd2, 5'd1, rv_pkg::F3_W);
    prog[6]  = enc_s(12'd4, 5'd3, 5'd1, rv_pkg::F3_W);
    prog[7]  = enc_s(12'd8, 5'd4, 5'd1, rv_pkg::F3_W);
    prog[8]  = enc_s(12'd12, 5'd5, 5'd1, rv_pkg::F3_W);
    prog[9]  = enc_i(12'h7a5, 5'd0, 3'd0, 5'd6, rv_pkg::OP_IMM);
    prog[10] = enc_s(12'd17, 5'd6, 5'd1, rv_pkg::F3_B);
    prog[11] = enc_s(12'd19, 5'd6, 5'd1, rv_pkg::F3_B);
    prog[12] = enc_s(12'd22, 5'd6, 5'd1, rv_pkg::F3_H);
    prog[13] = enc_s(12'd20, 5'd3, 5'd1, rv_pkg::F3_H);
    prog[14] = enc_s(12'hffc, 5'd6, 5'd1, rv_pkg::F3_W); // negative offset
    prog[15] = enc_i(12'd64, 5'd1, rv_pkg::F3_W, 5'd7, rv_pkg::OP_LOAD);
    prog[16] = enc_s(12'd32, 5'd7, 5'd1, rv_pkg::F3_W);
    prog[17] = enc_i(12'd65, 5'd1, rv_pkg::F3_B, 5'd8, rv_pkg::OP_LOAD);
    prog[18] = enc_s(12'd36, 5'd8, 5'd1, rv_pkg::F3_W);
    prog[19] = enc_i(12'd67, 5'd1, rv_pkg::F3_BU, 5'd9, rv_pkg::OP_LOAD);
    prog[20] = enc_s(12'd40, 5'd9, 5'd1, rv_pkg::F3_W);
    prog[21] = enc_i(12'd70, 5'd1, rv_pkg::F3_H, 5'd10, rv_pkg::OP_LOAD);
    prog[22] = enc_s(12'd44, 5'd10, 5'd1, rv_pkg::F3_W);
    prog[23] = enc_i(12'd66, 5'd1, rv_pkg::F3_HU, 5'd11, rv_pkg::OP_LOAD);
    prog[24] = enc_s(12'd48, 5'd11, 5'd1, rv_pkg::F3_W);
    prog[25] = enc_i(12'd17, 5'd1, rv_pkg::F3_B, 5'd12, rv_pkg::OP_LOAD);
    prog[26] = enc_s(12'd52, 5'd12, 5'd1, rv_pkg::F3_W);
    prog[27] = enc_i(12'd22, 5'd1, rv_pkg::F3_HU, 5'd13, rv_pkg::OP_LOAD);
    prog[28] = enc_s(12'd56, 5'd13, 5'd1, rv_pkg::F3_W);
    prog[29] = enc_j(21'd12, 5'd14);                    // skips two
    prog[30] = enc_i(12'd1, 5'd0, 3'd0, 5'd15, rv_pkg::OP_IMM);
    prog[31] = enc_i(12'd2, 5'd0, 3'd0, 5'd15, rv_pkg::OP_IMM);
    prog[32] = {20'h00000, 5'd16, rv_pkg::OP_AUIPC};
    prog[33] = enc_i(12'd13, 5'd16, 3'd0, 5'd17, rv_pkg::OP_JALR); // odd target
    prog[34] = enc_i(12'd3, 5'd0, 3'd0, 5'd15, rv_pkg::OP_IMM);
    prog[35] = enc_s(12'd60, 5'd14, 5'd1, rv_pkg::F3_W);
    prog[36] = enc_s(12'd64, 5'd17, 5'd1, rv_pkg::F3_W);
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  end

  // reference model, runs on pre-edge values
  always @(posedge clk) begin
    if (rst) begin
      exp_pc = rv_pkg::RESET_PC;
      halt_exp = 1'b0;
      ack_q = 1'b0;
      after_rst = 1'b1;
      for (int i = 0; i < 32; i++) rf[i] = '0;
    end else begin
      cycles++;
      assert (pc == exp_pc) else value_err("pc", exp_pc, pc);
      assert (halted == halt_exp) else value_err("halted", 32'(halt_exp), 32'(halted));
      if (after_rst) begin
        assert (!dbus_req.cyc && !dbus_req.stb) else report_fail("bus active after reset");
        after_rst = 1'b0;
        finish_test();
      end
      if (halt_exp) begin
        assert (!dbus_req.cyc) else report_fail("bus cycle started after halt");
        halt_cycles++;
      end else begin
        retired = 1'b1;
        idx = pc_off >> 2;
        r1v = rf[inst[19:15]];
        r2v = rf[inst[24:20]];
        immi = {{20{inst[31]}}, inst[31:20]};
        imms = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        addr = r1v + ((inst[6:0] == rv_pkg::OP_STORE) ? imms : immi);
        exp_pc = pc + 4;
        case (inst[6:0])
          rv_pkg::OP_IMM:   write_reg(inst[11:7], r1v + immi);
          rv_pkg::OP_LUI:   write_reg(inst[11:7], {inst[31:12], 12'h000});
          rv_pkg::OP_AUIPC: write_reg(inst[11:7], pc + {inst[31:12], 12'h000});
          rv_pkg::OP_JAL: begin
            exp_pc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            write_reg(inst[11:7], pc + 4);
          end
          rv_pkg::OP_JALR: begin
            exp_pc = (r1v + immi) & ~32'd1;
            write_reg(inst[11:7], pc + 4);
          end
          rv_pkg::OP_LOAD, rv_pkg::OP_STORE: begin
            sh = cap_word >> (8 * addr[1:0]);
            if (ack_q) begin
              ack_q = 1'b0;
              case (inst[14:12])
                rv_pkg::F3_B:  ldv = {{24{sh[7]}}, sh[7:0]};
                rv_pkg::F3_H:  ldv = {{16{sh[15]}}, sh[15:0]};
                rv_pkg::F3_BU: ldv = {24'h0, sh[7:0]};
                rv_pkg::F3_HU: ldv = {16'h0, sh[15:0]};
                default:       ldv = cap_word;
              endcase
              if (inst[6:0] == rv_pkg::OP_LOAD) write_reg(inst[11:7], ldv);
            end else begin
              retired = 1'b0;
              exp_pc = pc;
              if (dbus_rsp.ack) begin
                ack_q = 1'b1;
                cap_word = i_mem.mem[dbus_req.adr[9:2]];
                case (inst[14:12])
                  rv_pkg::F3_B, rv_pkg::F3_BU: exp_sel = 32'h1 << addr[1:0];
                  rv_pkg::F3_H, rv_pkg::F3_HU: exp_sel = 32'h3 << addr[1:0];
                  default:                     exp_sel = 32'hf;
                endcase
                assert (dbus_req.adr == addr) else value_err("adr", addr, dbus_req.adr);
                assert (dbus_req.we == (inst[6:0] == rv_pkg::OP_STORE))
                  else value_err("we", 32'(inst[6:0] == rv_pkg::OP_STORE), 32'(dbus_req.we));
                if (inst[6:0] == rv_pkg::OP_STORE) begin
                  assert (32'(dbus_req.sel) == exp_sel)
                    else value_err("sel", exp_sel, 32'(dbus_req.sel));
                  assert (dbus_req.dat_w == r2v << (8 * addr[1:0]))
                    else value_err("dat_w", r2v << (8 * addr[1:0]), dbus_req.dat_w);
                end
              end
            end
          end
          default: begin // ebreak
            halt_exp = 1'b1;
            exp_pc = pc;
          end
        endcase
        if (retired && test_idx < 5 && idx == test_end[test_idx - 1]) finish_test();
      end
      if (halt_cycles == HALT_WAIT || cycles >= TIMEOUT) begin
        if (cycles >= TIMEOUT) report_fail("timeout, core never halted");
        else finish_test();
        $display("tests %0d, cycles %0d, errors %0d", test_idx, cycles, errors);
        if (errors == 0) begin
          $display("sim passed");
        end else begin
          $display("sim failed");
        end
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

/* verif/tb_wb_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_wb_mem #(
  parameter int MAX_WAIT = 3
) (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::dbus_req_t req,
  output rv_pkg::dbus_rsp_t rsp
);

  rv_pkg::word_t mem [256]; // word index from adr[9:2]
  logic          busy;
  int            waits;

  function automatic rv_pkg::word_t fill_word(input logic [7:0] idx);
    return {idx | 8'h80, idx ^ 8'hc3, ~idx, idx * 8'd7};
  endfunction

  initial begin
    rsp = '0;
    busy = 1'b0;
    waits = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(i[7:0]);
    end
  end

  // ack registered, so a draw of zero answers on the first edge after stb
  always @(posedge clk) begin
    if (rst) begin
      rsp.ack <= 1'b0;
      busy    <= 1'b0;
    end else begin
      rsp.ack <= 1'b0;
      if (req.cyc && req.stb && !rsp.ack) begin
        if (!busy) begin
          waits = $urandom % (MAX_WAIT + 1); // random wait states
        end
        if (waits == 0) begin
          busy      <= 1'b0;
          rsp.ack   <= 1'b1;
          rsp.dat_r <= mem[req.adr[9:2]];
          for (int b = 0; b < 4; b++) begin
            if (req.we && req.sel[b]) mem[req.adr[9:2]][8*b +: 8] <= req.dat_w[8*b +: 8];
          end
        end else begin
          busy  <= 1'b1;
          waits = waits - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::word_t     inst,
  output rv_pkg::word_t     pc,
  output rv_pkg::dbus_req_t dbus_req,
  input  rv_pkg::dbus_rsp_t dbus_rsp,
  output logic              halted
);

  rv_pkg::ctrl_t     ctrl;
  rv_pkg::word_t     imm;
  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;
  rv_pkg::word_t     sum;     // also the memory address
  rv_pkg::word_t     next_pc;
  rv_pkg::word_t     rd_wdata;
  rv_pkg::word_t     load_data;
  logic              mem_done;
  logic              step;

  rv_decoder i_decoder (
    .inst (inst),
    .ctrl (ctrl),
    .imm  (imm),
    .rs1  (rs1),
    .rs2  (rs2)
  );

  rv_reg_file i_reg_file (
    .clk      (clk),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (step),
    .rd       (ctrl.rd),
    .rd_wdata (rd_wdata)
  );

  rv_exec i_exec (
    .pc        (pc),
    .ctrl      (ctrl),
    .imm       (imm),
    .rs1_data  (rs1_data),
    .load_data (load_data),
    .sum       (sum),
    .next_pc   (next_pc),
    .rd_wdata  (rd_wdata)
  );

  rv_lsu i_lsu (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .addr       (sum),
    .store_data (rs2_data),
    .dbus_req   (dbus_req),
    .dbus_rsp   (dbus_rsp),
    .load_data  (load_data),
    .mem_done   (mem_done)
  );

  rv_pc_ctrl i_pc_ctrl (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .next_pc  (next_pc),
    .mem_done (mem_done),
    .pc       (pc),
    .step     (step),
    .halted   (halted)
  );

endmodule

`default_nettype wire

/* rtl/rv_pc_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_pc_ctrl (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::word_t next_pc,
  input  logic          mem_done,
  output rv_pkg::word_t pc,
  output logic          step,
  output logic          halted
);

  logic advance;

  // plain instructions retire at once, memory ones wait for DONE
  assign advance = ~halted &
                   ((~ctrl.mem_rd & ~ctrl.mem_wr & ~ctrl.halt) | mem_done);

  // retire strobe qualified by reg_we, this is the regfile write enable
  assign step = advance & ctrl.reg_we;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= rv_pkg::RESET_PC;
      halted <= 1'b0;
    end else begin
      if (advance) begin
        pc <= next_pc;
      end
      if (ctrl.halt) begin
        halted <= 1'b1; // sticky until reset
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_lsu (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::ctrl_t     ctrl,
  input  rv_pkg::word_t     addr,
  input  rv_pkg::word_t     store_data,
  output rv_pkg::dbus_req_t dbus_req,
  input  rv_pkg::dbus_rsp_t dbus_rsp,
  output rv_pkg::word_t     load_data,
  output logic              mem_done
);

  rv_pkg::lsu_state_e state;
  logic               access;
  logic               cyc_q; // drives both cyc and stb
  logic               we_q;
  rv_pkg::word_t      adr_q;
  rv_pkg::word_t      dat_w_q;
  rv_pkg::byte_sel_t  sel_q;
  rv_pkg::word_t      rdata_q;
  rv_pkg::byte_sel_t  sel_d;
  rv_pkg::word_t      dat_w_d;
  rv_pkg::word_t      shifted;

  assign access = ctrl.mem_rd | ctrl.mem_wr;

  // lanes from size and low address bits
  always_comb begin
    case (ctrl.funct3)
      rv_pkg::F3_B, rv_pkg::F3_BU: sel_d = 4'b0001 << addr[1:0];
      rv_pkg::F3_H, rv_pkg::F3_HU: sel_d = 4'b0011 << addr[1:0];
      rv_pkg::F3_W:                sel_d = 4'b1111;
      default:                     sel_d = '0; // unsupported size
    endcase
  end

  assign dat_w_d = store_data << {addr[1:0], 3'b000}; // into addressed lanes

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rv_pkg::IDLE;
      cyc_q <= 1'b0;
    end else begin
      case (state)
        rv_pkg::IDLE: begin
          if (access) begin
            state <= rv_pkg::BUS;
            cyc_q <= 1'b1;
          end
        end
        rv_pkg::BUS: begin
          if (dbus_rsp.ack) begin // drop cyc/stb the cycle after ack
            state <= rv_pkg::DONE;
            cyc_q <= 1'b0;
          end
        end
        rv_pkg::DONE: state <= rv_pkg::IDLE;
        default:      state <= rv_pkg::IDLE;
      endcase
    end
  end

  // request payload held until ack, read data caught on the ack edge
  always_ff @(posedge clk) begin
    if (state == rv_pkg::IDLE && access) begin
      adr_q   <= addr;
      we_q    <= ctrl.mem_wr;
      sel_q   <= sel_d;
      dat_w_q <= dat_w_d;
    end
    if (state == rv_pkg::BUS && dbus_rsp.ack) begin
      rdata_q <= dbus_rsp.dat_r;
    end
  end

  always_comb begin
    dbus_req.cyc   = cyc_q;
    dbus_req.stb   = cyc_q;
    dbus_req.we    = we_q;
    dbus_req.adr   = adr_q;
    dbus_req.dat_w = dat_w_q;
    dbus_req.sel   = sel_q;
  end

  // addressed lane down to bit 0, then extend
  assign shifted = rdata_q >> {adr_q[1:0], 3'b000};

  always_comb begin
    case (ctrl.funct3)
      rv_pkg::F3_B:  load_data = {{24{shifted[7]}}, shifted[7:0]};
      rv_pkg::F3_H:  load_data = {{16{shifted[15]}}, shifted[15:0]};
      rv_pkg::F3_BU: load_data = {24'h00_0000, shifted[7:0]};
      rv_pkg::F3_HU: load_data = {16'h0000, shifted[15:0]};
      default:       load_data = shifted; // lw
    endcase
  end

  assign mem_done = (state == rv_pkg::DONE);

endmodule

`default_nettype wire

/* rtl/rv_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_reg_file (
  input  logic              clk,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     rd_wdata
);

  rv_pkg::word_t regs [rv_pkg::NUM_REGS];

  always_ff @(posedge clk) begin
    if (we && rd != '0) begin // x0 never written
      regs[rd] <= rd_wdata;
    end
  end

  // async read ports
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* rtl/rv_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec (
  input  rv_pkg::word_t pc,
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::word_t imm,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t load_data,
  output rv_pkg::word_t sum,
  output rv_pkg::word_t next_pc,
  output rv_pkg::word_t rd_wdata
);

  rv_pkg::word_t op_a;
  rv_pkg::word_t link;

  // one adder serves addi, auipc, jump targets and memory address
  assign op_a = ctrl.op_a_pc ? pc : rs1_data;
  assign sum  = op_a + imm;

  assign link = pc + 32'd4;

  // bit 0 cleared for jalr, jal targets are even anyway
  assign next_pc = ctrl.jump ? {sum[31:1], 1'b0} : link;

  always_comb begin
    case (ctrl.wb_src)
      rv_pkg::WB_SUM:  rd_wdata = sum;
      rv_pkg::WB_LINK: rd_wdata = link;      // jal, jalr
      rv_pkg::WB_LOAD: rd_wdata = load_data;
      rv_pkg::WB_IMM:  rd_wdata = imm;       // lui
    endcase
  end

endmodule

`default_nettype wire

/* rtl/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
  input  rv_pkg::word_t     inst,
  output rv_pkg::ctrl_t     ctrl,
  output rv_pkg::word_t     imm,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2
);

  rv_pkg::opcode_t opcode;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_s;
  rv_pkg::word_t   imm_u;
  rv_pkg::word_t   imm_j;

  assign opcode = inst[6:0];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  // immediates, sign taken from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000}; // already shifted
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl        = '0; // unknown opcode only advances pc
    ctrl.funct3 = inst[14:12];
    ctrl.rd     = inst[11:7];
    imm         = imm_i;
    case (opcode)
      rv_pkg::OP_IMM: begin // every funct3 runs as addi
        ctrl.reg_we = 1'b1;
        ctrl.wb_src = rv_pkg::WB_SUM;
      end
      rv_pkg::OP_LUI: begin
        ctrl.reg_we = 1'b1;
        ctrl.wb_src = rv_pkg::WB_IMM;
        imm         = imm_u;
      end
      rv_pkg::OP_AUIPC: begin
        ctrl.op_a_pc = 1'b1;
        ctrl.reg_we  = 1'b1;
        imm          = imm_u;
      end
      rv_pkg::OP_JAL: begin
        ctrl.op_a_pc = 1'b1;
        ctrl.reg_we  = 1'b1;
        ctrl.jump    = 1'b1;
        ctrl.wb_src  = rv_pkg::WB_LINK;
        imm          = imm_j;
      end
      rv_pkg::OP_JALR: begin
        ctrl.reg_we = 1'b1;
        ctrl.jump   = 1'b1;
        ctrl.wb_src = rv_pkg::WB_LINK;
      end
      rv_pkg::OP_LOAD: begin
        ctrl.reg_we = 1'b1;
        ctrl.mem_rd = 1'b1;
        ctrl.wb_src = rv_pkg::WB_LOAD;
      end
      rv_pkg::OP_STORE: begin
        ctrl.mem_wr = 1'b1;
        imm         = imm_s;
      end
      rv_pkg::OP_SYSTEM: begin
        // only ebreak is recognised, other system ops fall through
        if (inst[31:20] == 12'h001 && inst[19:7] == '0) begin
          ctrl.halt = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // widths that carry a meaning
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [3:0]  byte_sel_t;

  localparam word_t RESET_PC = 32'h8000_0000;
  localparam int    NUM_REGS = 32;

  // major opcodes
  localparam opcode_t OP_IMM    = 7'b001_0011;
  localparam opcode_t OP_LUI    = 7'b011_0111;
  localparam opcode_t OP_AUIPC  = 7'b001_0111;
  localparam opcode_t OP_JAL    = 7'b110_1111;
  localparam opcode_t OP_JALR   = 7'b110_0111;
  localparam opcode_t OP_LOAD   = 7'b000_0011;
  localparam opcode_t OP_STORE  = 7'b010_0011;
  localparam opcode_t OP_SYSTEM = 7'b111_0011;

  // access size and signedness
  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

  typedef enum logic [1:0] {
    WB_SUM,  // adder result
    WB_LINK, // pc + 4
    WB_LOAD,
    WB_IMM   // lui
  } wb_src_e;

  typedef struct packed {
    logic      op_a_pc; // adder takes pc, not rs1
    logic      reg_we;
    logic      mem_rd;
    logic      mem_wr;
    logic      jump;
    logic      halt;
    wb_src_e   wb_src;
    funct3_t   funct3;
    reg_addr_t rd;
  } ctrl_t;

  // wishbone classic master side
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    word_t     adr;
    word_t     dat_w;
    byte_sel_t sel;
  } dbus_req_t;

  typedef struct packed {
    logic  ack;
    word_t dat_r;
  } dbus_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    BUS,
    DONE
  } lsu_state_e;

endpackage

`default_nettype wire
